// File: tb/obj_stim.mem
// kind_addr_data: 1 = table write (word address, data), 2 = render line (line number),
// 3 = expected pixel (hdump, 13-bit pixel), 0 = end; unlisted pixels expect 0
// single object, hidden one, out of range one, end marker, object after the end
1_000_0014 1_001_0000 1_002_0010 1_003_1000 1_004_0200 1_005_0005
1_008_4014 1_009_0000 1_00a_0064 1_00b_1000 1_00c_0200 1_00d_0005
1_010_0064 1_011_0000 1_012_0064 1_013_1000 1_014_0200 1_015_0005
1_018_8000
1_020_0014 1_021_0000 1_022_0064 1_023_1000 1_024_0200 1_025_0005
2_000_0014
3_018_0151 3_019_0152 3_01b_0153 3_01c_0154 3_01e_0155
3_01f_0156 3_020_0157 3_021_0158 3_022_0159
// pitch +4 over lines 40 to 42, nothing on 43
1_000_0028 1_001_0002 1_002_0832 1_003_2000 1_004_0200 1_005_0221
2_000_0028 3_03a_0867 3_03b_0868 3_03c_0869
2_000_0029 3_03a_0868 3_03b_0869 3_03c_086a
2_000_002a 3_03a_0869 3_03b_086a 3_03c_086b
2_000_002b
// vertical flip with pitch -4, range 58 to 60
1_000_003c 1_001_000e 1_002_f8c8 1_003_3000 1_004_9200 1_005_027f
2_000_003a 3_0d0_1ffa 3_0d1_1ffb 3_0d2_1ffc
2_000_003b 3_0d0_1ff9 3_0d1_1ffa 3_0d2_1ffb
2_000_003c 3_0d0_1ff8 3_0d1_1ff9 3_0d2_1ffa
// horizontal flip, zoom 256 and zoom 1024 on one line
1_000_0050 1_001_8001 1_002_0020 1_003_0000 1_004_0200 1_005_0001
1_008_0050 1_009_0002 1_00a_0064 1_00b_1000 1_00c_0100 1_00d_0002
1_010_0050 1_011_0000 1_012_0096 1_013_2000 1_014_0400 1_015_0003
2_000_0050
3_028_0046 3_029_0045 3_02b_0044 3_02c_0043 3_02e_0042 3_02f_0041
3_06c_0097 3_06d_0097 3_06e_0098 3_06f_0098 3_070_0099 3_071_0099
3_09e_00e1 3_0a0_00e4 3_0a1_00e5 3_0a2_00e7 3_0a3_00e9 3_0a4_00e5
// overlap, object 0 in front, drawn twice
1_000_005a 1_001_0000 1_002_0010 1_003_1000 1_004_0200 1_005_0005
1_008_005a 1_009_0001 1_00a_0012 1_00b_1000 1_00c_0200 1_00d_0002
1_010_0064
2_000_005a
3_018_0151 3_019_0152 3_01a_0094 3_01b_0153 3_01c_0154 3_01d_0096
3_01e_0155 3_01f_0156 3_020_0157 3_021_0158 3_022_0159
2_000_005a
3_018_0151 3_019_0152 3_01a_0094 3_01b_0153 3_01c_0154 3_01d_0096
3_01e_0155 3_01f_0156 3_020_0157 3_021_0158 3_022_0159
0_000_0000

// File: flist.f
verilog/obj_pkg.sv
verilog/video_pkg.sv
verilog/obj_ram.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_linebuf.sv
verilog/obj_top.sv
tb/obj_tb.sv

// File: Bender.yml
package:
  name: obj_engine

sources:
  - verilog/obj_pkg.sv
  - verilog/video_pkg.sv
  - verilog/obj_ram.sv
  - verilog/obj_scan.sv
  - verilog/obj_draw.sv
  - verilog/obj_linebuf.sv
  - verilog/obj_top.sv
  - target: test
    files:
      - tb/obj_tb.sv

// File: tb/obj_tb.sv
`timescale 1ns/1ps
`default_nettype none

module obj_tb
    import video_pkg::*;
();

    localparam int STIM_LEN   = 256;
    localparam int LINE_WAIT  = 2000;   // far more than any scan plus draw
    localparam int LINE_COST  = 2600;   // watchdog budget per line

    logic        clk = 1'b0;
    logic        rst;
    logic [ 9:0] cpu_addr;
    logic [15:0] cpu_din;
    logic        cpu_we;
    logic        hstart;
    line_t       vrender;
    hpos_t       hdump;
    logic [17:0] rom_addr;
    logic        rom_cs;
    logic [15:0] rom_data;
    logic        rom_ok;
    lb_pixel_t   pix;

    logic [31:0] stim [0:STIM_LEN-1];
    logic [12:0] exp_pix [0:511];
    int          err_cnt = 0;
    int          line_cnt = 0;
    logic        stim_ready = 1'b0;
    logic [1:0]  rom_wait;

    obj_top #(.PXL_DLY(9'd8)) UUT (
        .rst, .clk, .cpu_addr, .cpu_din, .cpu_we,
        .hstart, .vrender, .hdump,
        .rom_addr, .rom_cs, .rom_data, .rom_ok,
        .pix
    );

    always #2 clk = ~clk;

    // sprite rom word pattern follows a[1:0] and a[3:2] lifts the opaque nibbles
    function automatic logic [15:0] rom_word(input logic [17:0] a);
        logic [15:0] pat;
        logic [15:0] w;
        logic [3:0]  nib;
        case (a[1:0])
            2'd0:    pat = 16'h1203;
            2'd1:    pat = 16'h4056;
            2'd2:    pat = 16'h789f;
            default: pat = 16'h56ff;
        endcase
        for (int k = 0; k < 4; k++) begin
            nib = pat[4*k +: 4];
            if (nib != 4'd0 && nib != 4'd15) begin
                nib = nib + {2'b00, a[3:2]};
            end
            w[4*k +: 4] = nib;
        end
        return w;
    endfunction

    assign rom_data = rom_word(rom_addr);

    // answer each request after 0 to 3 cycles
    initial begin
        void'($urandom(32'haab3_c993));
        forever begin
            @(posedge clk);
            rom_ok <= 1'b0;
            if (rom_cs && !rom_ok && !rst) begin
                if (rom_wait == 2'd0) begin
                    rom_ok <= 1'b1;
                end else begin
                    rom_wait <= rom_wait - 2'd1;
                end
            end else begin
                rom_wait <= 2'($urandom % 4);
            end
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            err_cnt++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, want);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic cpu_write(input logic [9:0] addr, input logic [15:0] data);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_din  <= data;
        cpu_we   <= 1'b1;
    endtask

    // draw one line then swap and play it out against the expected pixels
    task automatic run_line(input line_t ln);
        @(posedge clk);
        cpu_we  <= 1'b0;
        vrender <= ln;
        hstart  <= 1'b1;
        @(posedge clk);
        hstart <= 1'b0;
        repeat (LINE_WAIT) @(posedge clk);
        vrender <= 9'h1ff;          // nothing drawn during play-out
        hstart  <= 1'b1;
        @(posedge clk);
        hstart <= 1'b0;
        hdump  <= 9'd0;
        for (int h = 1; h <= 512; h++) begin
            @(posedge clk);
            if (h < 512) begin
                hdump <= hpos_t'(h);
            end
            @(negedge clk);
            check(32'(pix), 32'(exp_pix[h-1]), $sformatf("line %0d hdump %0d", ln, h - 1));
        end
        check(32'(rom_cs), 32'd0, $sformatf("rom_cs idle after line %0d", ln));
    endtask

    initial begin
        int i;
        line_t ln;
        rst      = 1'b1;
        cpu_addr = '0;
        cpu_din  = '0;
        cpu_we   = 1'b0;
        hstart   = 1'b0;
        vrender  = '0;
        hdump    = '0;
        rom_ok   = 1'b0;
        rom_wait = 2'd0;
        $readmemh("tb/obj_stim.mem", stim);
        if (^stim[0] === 1'bx) begin
            $display("stimulus file tb/obj_stim.mem could not be read");
            $display("ERRORS FOUND");
            $fatal(1, "no stimulus");
        end
        for (int k = 0; k < STIM_LEN; k++) begin
            if (stim[k][31:28] === 4'h2) begin
                line_cnt++;
            end
        end
        stim_ready = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check(32'(rom_cs), 32'd0, "rom_cs after reset");
        check(32'(pix), 32'd0, "pix after reset");
        i = 0;
        while (i < STIM_LEN && stim[i][31:28] !== 4'h0) begin
            case (stim[i][31:28])
                4'h1: begin
                    cpu_write(stim[i][25:16], stim[i][15:0]);
                    i++;
                end
                4'h2: begin
                    ln = stim[i][8:0];
                    for (int h = 0; h < 512; h++) begin
                        exp_pix[h] = '0;    // untouched spots stay empty
                    end
                    i++;
                    while (i < STIM_LEN && stim[i][31:28] === 4'h3) begin
                        exp_pix[stim[i][24:16]] = stim[i][12:0];
                        i++;
                    end
                    run_line(ln);
                end
                default: begin
                    $display("unknown stimulus record %h at entry %0d", stim[i], i);
                    $display("ERRORS FOUND");
                    $fatal(1, "bad stimulus");
                end
            endcase
        end
        if (err_cnt == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "checks failed");
        end
    end

    // watchdog sized from the number of lines in the stimulus
    initial begin
        wait (stim_ready);
        repeat ((line_cnt + 2) * LINE_COST) @(posedge clk);
        $display("timeout: the run took longer than the lines allow");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: verilog/obj_top.sv
`timescale 1ns/1ps
`default_nettype none

module obj_top
    import obj_pkg::*;
    import video_pkg::*;
#(
    parameter logic [8:0] PXL_DLY = 9'd8    // matches the play-out delay
) (
    input  wire          rst,
    input  wire          clk,

    input  wire  [ 9:0]  cpu_addr,
    input  wire  [15:0]  cpu_din,
    input  wire          cpu_we,

    input  wire          hstart,
    input  wire line_t   vrender,
    input  wire hpos_t   hdump,

    output logic [17:0]  rom_addr,
    output logic         rom_cs,
    input  wire  [15:0]  rom_data,
    input  wire          rom_ok,

    output lb_pixel_t    pix
);

    logic [ 9:0]  tbl_addr;
    logic [15:0]  tbl_din, tbl_dout;
    logic         tbl_we;

    logic         dr_start, dr_busy;
    hpos_t        dr_xpos;
    obj_offset_u  dr_offset;
    bank_t        dr_bank;
    prio_t        dr_prio;
    pal_t         dr_pal;
    zoom_t        dr_hzoom;

    logic         buf_we;
    hpos_t        buf_addr;
    lb_pixel_t    buf_wpix;

    obj_ram u_ram (
        .clk, .cpu_addr, .cpu_din, .cpu_we,
        .tbl_addr, .tbl_din, .tbl_we, .tbl_dout
    );

    obj_scan u_scan (
        .rst, .clk, .hstart, .vrender,
        .tbl_addr, .tbl_din, .tbl_we, .tbl_dout,
        .dr_start, .dr_xpos, .dr_offset, .dr_bank, .dr_prio, .dr_pal, .dr_hzoom,
        .dr_busy
    );

    obj_draw #(.PXL_DLY(PXL_DLY)) u_draw (
        .rst, .clk,
        .dr_start, .dr_xpos, .dr_offset, .dr_bank, .dr_prio, .dr_pal, .dr_hzoom,
        .dr_busy,
        .rom_addr, .rom_cs, .rom_data, .rom_ok,
        .buf_we, .buf_addr, .buf_wpix
    );

    obj_linebuf u_linebuf (
        .rst, .clk, .hstart,
        .buf_we, .buf_addr, .buf_wpix,
        .hdump, .pix
    );

endmodule

`default_nettype wire

// File: verilog/obj_linebuf.sv
`timescale 1ns/1ps
`default_nettype none

module obj_linebuf
    import video_pkg::*;
(
    input  wire             rst,
    input  wire             clk,
    input  wire             hstart,

    // write side, from the draw engine
    input  wire             buf_we,
    input  wire hpos_t      buf_addr,
    input  wire lb_pixel_t  buf_wpix,

    // play-out side
    input  wire hpos_t      hdump,
    output lb_pixel_t       pix
);

    lb_pixel_t     mem [0:1023];   // two halves of 512
    logic [1023:0] used;           // location taken this line
    logic          wsel;           // half being drawn
    logic [9:0]    wa, ra;
    logic          wr;

    assign wa = {wsel, buf_addr};
    assign ra = {~wsel, hdump};

    // first writer keeps the spot, so lower object numbers stay in front
    assign wr = buf_we && !used[wa];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wsel <= 1'b0;
            used <= '0;
            pix  <= '0;
        end else begin
            if (hstart) begin
                wsel <= ~wsel;
            end
            pix      <= used[ra] ? mem[ra] : '0;
            used[ra] <= 1'b0;   // erased once shown
            if (wr) begin
                used[wa] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wa] <= buf_wpix;
        end
    end

endmodule

`default_nettype wire

// File: verilog/obj_draw.sv
`timescale 1ns/1ps
`default_nettype none

module obj_draw
    import obj_pkg::*;
    import video_pkg::*;
#(
    parameter logic [8:0] PXL_DLY = 9'd8
) (
    input  wire          rst,
    input  wire          clk,

    // command from the scanner
    input  wire          dr_start,
    input  wire hpos_t   dr_xpos,
    input  wire obj_offset_u dr_offset,
    input  wire bank_t   dr_bank,
    input  wire prio_t   dr_prio,
    input  wire pal_t    dr_pal,
    input  wire zoom_t   dr_hzoom,
    output logic         dr_busy,

    // sprite rom
    output logic [17:0]  rom_addr,
    output logic         rom_cs,
    input  wire  [15:0]  rom_data,
    input  wire          rom_ok,

    // line buffer
    output logic         buf_we,
    output hpos_t        buf_addr,
    output lb_pixel_t    buf_wpix
);

    logic        hflip;
    logic [14:0] waddr;         // rom word address
    bank_t       bank;
    prio_t       prio;
    pal_t        pal;
    zoom_t       hzoom;
    logic [10:0] step;          // a zoom field of 0 stands for 1024
    logic [10:0] acc;           // [10:9] picks the pixel inside the word
    logic [11:0] acc_nx;
    logic [8:0]  cnt;           // output pixels so far
    hpos_t       xcur;
    logic [15:0] word;
    logic        have_word;
    logic        drawing, done;
    logic [1:0]  sel;
    logic [3:0]  color;

    assign rom_addr = {bank, waddr};
    assign drawing  = dr_busy && have_word;
    assign step     = {hzoom == '0, hzoom};
    assign acc_nx   = {1'b0, acc} + {1'b0, step};
    assign sel      = hflip ? ~acc[10:9] : acc[10:9];
    assign color    = word[{~sel, 2'b00} +: 4];     // leftmost pixel in the top nibble
    assign done     = color == COLOR_END || cnt == 9'd511;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dr_busy   <= 1'b0;
            rom_cs    <= 1'b0;
            have_word <= 1'b0;
            buf_we    <= 1'b0;
        end else begin
            buf_we <= 1'b0;
            if (dr_start) begin
                dr_busy   <= 1'b1;
                rom_cs    <= 1'b1;  // first word
                have_word <= 1'b0;
            end else begin
                if (rom_cs && rom_ok) begin
                    rom_cs    <= 1'b0;
                    have_word <= 1'b1;
                end
                if (drawing) begin
                    if (color != COLOR_END && color != COLOR_EMPTY) begin
                        buf_we <= 1'b1;
                    end
                    if (done) begin
                        dr_busy <= 1'b0;
                    end else if (acc_nx[11]) begin
                        have_word <= 1'b0;  // crossed into the next word
                        rom_cs    <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dr_start) begin
            hflip <= dr_offset.fl.hflip;
            waddr <= dr_offset.fl.addr;
            bank  <= dr_bank;
            prio  <= dr_prio;
            pal   <= dr_pal;
            hzoom <= dr_hzoom;
            acc   <= '0;
            cnt   <= '0;
            xcur  <= dr_xpos + PXL_DLY;
        end else begin
            if (rom_cs && rom_ok) begin
                word <= rom_data;
            end
            if (drawing) begin
                acc      <= acc_nx[10:0];
                cnt      <= cnt + 9'd1;
                xcur     <= xcur + 9'd1;
                buf_addr <= xcur;
                buf_wpix <= {pal, prio, color};
                if (acc_nx[11]) begin
                    waddr <= hflip ? waddr - 15'd1 : waddr + 15'd1;  // flipped runs backwards
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/obj_scan.sv
`timescale 1ns/1ps
`default_nettype none

module obj_scan
    import obj_pkg::*;
    import video_pkg::*;
(
    input  wire          rst,
    input  wire          clk,

    input  wire          hstart,
    input  wire line_t   vrender,

    // object table
    output logic [ 9:0]  tbl_addr,
    output logic [15:0]  tbl_din,
    output logic         tbl_we,
    input  wire  [15:0]  tbl_dout,

    // draw commands
    output logic         dr_start,
    output hpos_t        dr_xpos,
    output obj_offset_u  dr_offset,
    output bank_t        dr_bank,
    output prio_t        dr_prio,
    output pal_t         dr_pal,
    output zoom_t        dr_hzoom,
    input  wire          dr_busy
);

    localparam logic [3:0] ST_IDLE = 4'd0;
    localparam logic [3:0] ST_WAIT = 4'd9;

    logic [3:0]         st;
    obj_idx_t           cur_obj;
    tbl_idx_t           idx;
    logic               skip, issue;

    // entry being looked at
    line_t              top, bottom;
    logic               visible, vflip;
    obj_offset_u        offset;
    hpos_t              xpos;
    logic signed [15:0] pitch;
    bank_t              bank;
    prio_t              prio;
    pal_t               pal;
    zoom_t              hzoom;

    assign tbl_addr = {cur_obj, idx};
    assign tbl_din  = offset.raw;

    assign skip  = !visible || vrender < top || vrender > bottom;
    assign issue = st == ST_WAIT && !hstart && !dr_busy && !dr_start;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= ST_IDLE;
            cur_obj  <= '0;
            idx      <= W_TOP;
            tbl_we   <= 1'b0;
            dr_start <= 1'b0;
        end else begin
            tbl_we   <= 1'b0;
            dr_start <= 1'b0;
            case (st)
                ST_IDLE: begin
                    cur_obj <= '0;
                    idx     <= W_TOP;
                    if (hstart && vrender <= LAST_VIS_LINE) begin
                        st <= 4'd1;
                    end
                end
                4'd7: st <= 4'd8;   // scratch word on its way
                4'd8: begin
                    if (skip) begin
                        if (&cur_obj) begin
                            st <= ST_IDLE;
                        end else begin
                            cur_obj <= cur_obj + 7'd1;
                            idx     <= W_TOP;
                            st      <= 4'd1;
                        end
                    end else begin
                        tbl_we <= 1'b1;     // new offset into the scratch word
                        st     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (hstart) begin
                        st <= ST_IDLE;      // line ran out, give up
                    end else if (issue) begin
                        dr_start <= 1'b1;
                        if (&cur_obj) begin
                            st <= ST_IDLE;
                        end else begin
                            cur_obj <= cur_obj + 7'd1;
                            idx     <= W_TOP;
                            st      <= 4'd1;
                        end
                    end
                end
                default: begin
                    // states 1 to 6 step through the entry words
                    st  <= st + 4'd1;
                    idx <= (idx == W_PAL) ? W_SCRATCH : idx + 3'd1;
                    if (st == 4'd2 && tbl_dout[15]) begin
                        st <= ST_IDLE;      // end of list
                    end
                end
            endcase
        end
    end

    // entry fields, each word shows up one state after its address
    always_ff @(posedge clk) begin
        case (st)
            4'd2: begin
                top     <= tbl_dout[8:0];
                visible <= !tbl_dout[14];
                bank    <= tbl_dout[11:9];
            end
            4'd3: offset.raw <= tbl_dout;
            4'd4: begin
                xpos       <= tbl_dout[8:0];
                pitch[6:0] <= tbl_dout[15:9];
            end
            4'd5: prio <= tbl_dout[13:12];  // vertical zoom bits unused
            4'd6: begin
                vflip       <= tbl_dout[15];
                pitch[15:7] <= {9{tbl_dout[12]}};
                hzoom       <= tbl_dout[9:0];
            end
            4'd7: begin
                pal <= tbl_dout[6:0];
                if (vflip) begin
                    // range mirrored about the top line
                    top    <= top - {1'b0, tbl_dout[15:8]};
                    bottom <= top;
                end else begin
                    bottom <= top + {1'b0, tbl_dout[15:8]};
                end
            end
            4'd8: begin
                if (vrender != top) begin
                    offset.raw <= tbl_dout + pitch;     // scratch plus pitch
                end
            end
            default: ;
        endcase

        if (issue) begin
            dr_xpos   <= xpos;
            dr_offset <= offset;
            dr_bank   <= bank;
            dr_prio   <= prio;
            dr_pal    <= pal;
            dr_hzoom  <= hzoom;
        end
    end

endmodule

`default_nettype wire

// File: verilog/obj_ram.sv
`timescale 1ns/1ps
`default_nettype none

module obj_ram (
    input  wire         clk,

    // cpu side, write only
    input  wire  [ 9:0] cpu_addr,
    input  wire  [15:0] cpu_din,
    input  wire         cpu_we,

    // scanner side
    input  wire  [ 9:0] tbl_addr,
    input  wire  [15:0] tbl_din,
    input  wire         tbl_we,
    output logic [15:0] tbl_dout
);

    // 128 entries of 8 words
    logic [15:0] mem [0:1023];

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        if (tbl_we) begin
            mem[tbl_addr] <= tbl_din;   // running offset write-back
        end
        tbl_dout <= mem[tbl_addr];      // one cycle read
    end

endmodule

`default_nettype wire

// File: verilog/video_pkg.sv
`default_nettype none

package video_pkg;
    import obj_pkg::*;

    typedef logic [8:0] line_t;
    typedef logic [8:0] hpos_t;

    localparam line_t LAST_VIS_LINE = 9'd223;

    // what one line buffer location holds
    typedef struct packed {
        pal_t       pal;
        prio_t      prio;
        logic [3:0] color;      // 0 is empty
    } lb_pixel_t;

    localparam logic [3:0] COLOR_EMPTY = 4'd0;
    localparam logic [3:0] COLOR_END   = 4'd15;  // stops the object line

endpackage

`default_nettype wire

// File: verilog/obj_pkg.sv
`default_nettype none

package obj_pkg;

    // object number and word index inside one table entry
    typedef logic [6:0] obj_idx_t;
    typedef logic [2:0] tbl_idx_t;

    // word 0: [15] end of list, [14] hidden, [11:9] rom bank, [8:0] top line
    localparam tbl_idx_t W_TOP     = 3'd0;
    // word 1: start offset, see obj_offset_u
    localparam tbl_idx_t W_OFFSET  = 3'd1;
    // word 2: [15:9] pitch low bits, [8:0] x position
    localparam tbl_idx_t W_XPOS    = 3'd2;
    // word 3: [13:12] priority, [9:0] vertical zoom
    localparam tbl_idx_t W_VZOOM   = 3'd3;
    // word 4: [15] vertical flip, [12] pitch sign, [9:0] horizontal zoom
    localparam tbl_idx_t W_HZOOM   = 3'd4;
    // word 5: [15:8] height in lines, [6:0] palette
    localparam tbl_idx_t W_PAL     = 3'd5;
    // word 7: running offset, rewritten by the scanner every line
    localparam tbl_idx_t W_SCRATCH = 3'd7;

    // one offset word, read two ways
    typedef union packed {
        logic [15:0] raw;       // plain word address, stepped by the pitch
        struct packed {
            logic        hflip;
            logic [14:0] addr;
        } fl;                   // what the draw engine fetches from
    } obj_offset_u;

    // 512 is one source pixel per output pixel
    typedef logic [9:0] zoom_t;

    typedef logic [6:0] pal_t;
    typedef logic [2:0] bank_t;
    typedef logic [1:0] prio_t;

endpackage

`default_nettype wire
